//--- common/uart_defs.svh
// --------------------
// Baud figures are fixed at build time; CLK_FREQ must be a whole multiple of BAUD_RATE
// --------------------

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Short clock so simulation stays fast
`define UART_CLK_FREQ      1600000
`define UART_BAUD_RATE     100000
`define UART_DATA_BITS     8       // No parity, one stop bit on transmit

// Clocks in one bit period, 16 here
`define UART_CLKS_PER_BIT  (`UART_CLK_FREQ / `UART_BAUD_RATE)

`define UART_RX_FIFO_DEPTH 8  // Received words
`define UART_TX_FIFO_DEPTH 4  // Bytes waiting to go out

`endif

//--- common/uart_pkg.sv
// --------------------
// Widths follow the macros in uart_defs.svh
// --------------------

`include "uart_defs.svh"

package uart_pkg;

	// One character
	typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

	// Counts clocks within one bit period
	typedef logic [$clog2(`UART_CLKS_PER_BIT)-1:0] baud_cnt_t;

	// Start bit, data bits and stop bit
	typedef logic [$clog2(`UART_DATA_BITS+2)-1:0] bit_cnt_t;

	typedef enum logic {
		RX_IDLE,    // Waiting for a falling edge
		RX_CAPTURE  // Inside a frame
	} rx_state_t;

	typedef enum logic {
		TX_IDLE,  // Line held high
		TX_SHIFT  // Frame going out
	} tx_state_t;

	// Received character with its status
	typedef struct packed {
		logic       frame_err; // Stop bit read low
		uart_byte_t data;
	} rx_word_t;

endpackage

//--- run.sh
#!/bin/sh
# Builds the UART core testbench with Verilator and runs it
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module uart_core_tb -o uart_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/uart_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

//--- uart/uart_rx.sv
// --------------------
// 8N1 receiver, any number of stop bits, one sample per bit at the midpoint
// rx_data is only meaningful in the cycle rx_valid is high
// --------------------

`include "uart_defs.svh"

module uart_rx (
	input  logic               clk,
	input  logic               sresetn,
	input  logic               serial_in,
	output logic               rx_valid,
	output uart_pkg::rx_word_t rx_data
);

	import uart_pkg::*;

	localparam baud_cnt_t LAST_BAUD = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
	localparam baud_cnt_t HALF_BIT  = baud_cnt_t'(`UART_CLKS_PER_BIT / 2); // Midpoint
	localparam bit_cnt_t  STOP_IDX  = bit_cnt_t'(`UART_DATA_BITS + 1);     // Start is index 0

	rx_state_t state;
	baud_cnt_t baud_cnt;  // Clock within current bit
	bit_cnt_t  bit_cnt;   // Current bit of the frame
	logic      line;      // Synchronized serial input
	logic      line_prev; // Previous sample, for edge detection
	logic      sample_now;

	// Pin to clock domain
	cdc_sync sync_i (
		.clk      (clk),
		.sresetn  (sresetn),
		.in_async (serial_in),
		.out_sync (line)
	);

	assign sample_now = (state == RX_CAPTURE) && (baud_cnt == HALF_BIT);

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state     <= RX_IDLE;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			rx_valid  <= 1'b0;
			line_prev <= 1'b1;
		end else begin
			rx_valid  <= 1'b0; // Pulse only
			line_prev <= line;
			case (state)
				RX_IDLE: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					// Falling edge only, so a low stop bit cannot start a false frame
					if (!line && line_prev)
						state <= RX_CAPTURE;
				end
				RX_CAPTURE: begin
					if (baud_cnt == LAST_BAUD) begin // Bit period done
						baud_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
					// Done at stop midpoint, ready for the next start edge
					if (sample_now && bit_cnt == STOP_IDX) begin
						state    <= RX_IDLE;
						rx_valid <= 1'b1;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge clk) begin
		if (sample_now) begin
			if (bit_cnt == STOP_IDX)
				rx_data.frame_err <= ~line; // Stop must be high
			else if (bit_cnt != '0) // Skip the start bit
				rx_data.data <= {line, rx_data.data[`UART_DATA_BITS-1:1]}; // LSB arrives first
		end
	end

endmodule

//--- uart/uart_tx.sv
// --------------------
// 8N1 serializer; start is taken only while busy is low
// --------------------

`include "uart_defs.svh"

module uart_tx (
	input  logic                 clk,
	input  logic                 sresetn,
	input  logic                 start,
	input  uart_pkg::uart_byte_t tx_byte,
	output logic                 serial_out,
	output logic                 busy
);

	import uart_pkg::*;

	localparam int        FRAME_BITS = `UART_DATA_BITS + 2; // Start, data, stop
	localparam baud_cnt_t LAST_BAUD  = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
	localparam bit_cnt_t  LAST_BIT   = bit_cnt_t'(FRAME_BITS - 1);

	tx_state_t               state;
	baud_cnt_t               baud_cnt;
	bit_cnt_t                bit_cnt;   // Bit now on the line
	logic [FRAME_BITS-1:0]   shift_reg; // LSB drives the line

	// Line reads high whenever nothing is shifting
	assign serial_out = shift_reg[0];
	assign busy       = (state == TX_SHIFT);

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			state     <= TX_IDLE;
			baud_cnt  <= '0;
			bit_cnt   <= '0;
			shift_reg <= '1; // Idle high
		end else begin
			case (state)
				TX_IDLE: begin
					baud_cnt <= '0;
					bit_cnt  <= '0;
					if (start) begin
						shift_reg <= {1'b1, tx_byte, 1'b0}; // Stop, data, start
						state     <= TX_SHIFT;
					end
				end
				TX_SHIFT: begin
					if (baud_cnt == LAST_BAUD) begin
						baud_cnt  <= '0;
						// Fill with ones so the line rests high after the stop bit
						shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
						if (bit_cnt == LAST_BIT)
							state <= TX_IDLE; // Tenth period over
						else
							bit_cnt <= bit_cnt + 1'b1;
					end else begin
						baud_cnt <= baud_cnt + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

//--- verification/uart_tb_util.svh
// --------------------
// Included inside uart_core_tb, uses its clk, drive_line, serial_out, lfsr_state and queues
// --------------------

`ifndef UART_TB_UTIL_SVH
`define UART_TB_UTIL_SVH

	// 16-bit Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 16'hB400;
		return n;
	endfunction

	// One LFSR step per bit taken, first bit ends up as MSB
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		int          k;
		val = '0;
		for (k = 0; k < n; k++) begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		return val;
	endfunction

	// Hold one bit on the driver side for a full bit period
	task automatic drive_bit(input logic level);
		drive_line <= level;
		repeat (`UART_CLKS_PER_BIT) @(posedge clk);
	endtask

	// Start, data LSB first, stop; a low stop is followed by one idle bit
	task automatic send_frame(input uart_byte_t data, input logic stop_level, input int stop_bits);
		int k;
		drive_bit(1'b0);
		for (k = 0; k < `UART_DATA_BITS; k++)
			drive_bit(data[k]);
		drive_bit(stop_level);
		for (k = 1; k < stop_bits; k++)
			drive_bit(1'b1); // Extra stop bits
		if (!stop_level)
			drive_bit(1'b1); // Line back to idle
	endtask

	// Samples serial_out at each bit midpoint
	task automatic capture_frame(output logic start_bit, output uart_byte_t data,
			output logic stop_bit);
		int k;
		@(negedge serial_out);
		repeat (`UART_CLKS_PER_BIT / 2) @(posedge clk);
		start_bit = serial_out;
		for (k = 0; k < `UART_DATA_BITS; k++) begin
			repeat (`UART_CLKS_PER_BIT) @(posedge clk);
			data[k] = serial_out;
		end
		repeat (`UART_CLKS_PER_BIT) @(posedge clk);
		stop_bit = serial_out;
	endtask

	// Model entry for one received character
	task automatic expect_word(input logic err, input uart_byte_t data);
		rx_word_t w;
		w.frame_err = err;
		w.data      = data;
		exp_rx.push_back(w);
	endtask

	// Until every expected word has been popped and the FIFO reads empty
	task automatic wait_drained();
		@(posedge clk);
		while (exp_rx.size() != 0 || !rx_empty || rx_pop)
			@(posedge clk);
	endtask

`endif

//--- verification/uart_core_tb.sv
// --------------------
// Random bytes from a fixed LFSR seed are checked against model queues
// --------------------

`include "uart_defs.svh"

module uart_core_tb;

	import uart_pkg::*;

	localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
	localparam int CLK_PERIOD = 4;
	localparam int N_FRAMES   = 20 + 12 + 20 + 10 + 12; // All tests together
	localparam int WATCHDOG   = N_FRAMES * 10 * BIT_CLKS * CLK_PERIOD * 2 + 2000 * CLK_PERIOD;

	logic        clk = 1'b0;
	logic        sresetn = 1'b0;
	logic        serial_in;
	logic        serial_out;
	logic        tx_push = 1'b0;
	uart_byte_t  tx_byte = '0;
	logic        tx_full;
	logic        rx_pop = 1'b0;
	rx_word_t    rx_word;
	logic        rx_empty;
	logic        rx_overrun;

	logic        drive_line = 1'b1; // Driver side level that idles high
	logic        loopback = 1'b0;   // serial_out fed back to serial_in
	logic        auto_pop = 1'b0;   // Background pop and compare
	logic [15:0] lfsr_state = 16'd31704;
	int          overrun_cnt = 0;
	logic        overrun_prev = 1'b0; // rx_overrun one cycle back
	string       test_name = "reset";
	rx_word_t    exp_rx[$];         // Words the host should pop in order
	uart_byte_t  exp_tx[$];         // Bytes due on serial_out

	assign serial_in = loopback ? serial_out : drive_line;

	always #(CLK_PERIOD / 2) clk = ~clk;

	uart_core uart_core_i (
		.clk        (clk),
		.sresetn    (sresetn),
		.serial_in  (serial_in),
		.serial_out (serial_out),
		.tx_push    (tx_push),
		.tx_byte    (tx_byte),
		.tx_full    (tx_full),
		.rx_pop     (rx_pop),
		.rx_word    (rx_word),
		.rx_empty   (rx_empty),
		.rx_overrun (rx_overrun)
	);

	`include "uart_tb_util.svh"

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		fail_run($sformatf("mismatch in %s: %s expected 0x%0h actual 0x%0h",
			test_name, what, expected, actual));
	endtask

	// Push n random bytes as tx_full allows with one strobe per push
	task automatic push_bytes(input int n, input logic echo);
		uart_byte_t b;
		int         k;
		for (k = 0; k < n; k++) begin
			while (tx_full)
				@(posedge clk);
			b = 8'(rand_bits(8));
			tx_byte <= b;
			tx_push <= 1'b1;
			if (echo)
				expect_word(1'b0, b); // Comes back on rx_word
			else
				exp_tx.push_back(b);
			@(posedge clk);
			tx_push <= 1'b0;
			repeat (rand_bits(2)) @(posedge clk); // Random gap
			@(posedge clk); // tx_full now shows the last push
		end
	endtask

	task automatic check_tx_frames(input int n);
		logic       start_bit;
		logic       stop_bit;
		uart_byte_t data;
		uart_byte_t exp_byte;
		int         k;
		for (k = 0; k < n; k++) begin
			capture_frame(start_bit, data, stop_bit);
			assert (start_bit == 1'b0) else report_mismatch("start bit", 0, 32'(start_bit));
			assert (stop_bit == 1'b1) else report_mismatch("stop bit", 1, 32'(stop_bit));
			assert (exp_tx.size() != 0)
				else fail_run("a frame left serial_out with no byte pushed");
			exp_byte = exp_tx.pop_front();
			assert (data == exp_byte)
				else report_mismatch("tx byte", 32'(exp_byte), 32'(data));
		end
	endtask

	// Host side of the receive FIFO
	always @(posedge clk) begin
		rx_word_t exp_word;
		if (rx_pop) begin
			rx_pop <= 1'b0; // FIFO updates over this edge
		end else if (auto_pop && !rx_empty) begin
			assert (exp_rx.size() != 0)
				else fail_run("receive FIFO returned a word never sent");
			exp_word = exp_rx.pop_front();
			assert (rx_word == exp_word)
				else report_mismatch("rx_word", 32'(exp_word), 32'(rx_word));
			rx_pop <= 1'b1;
		end
	end

	// Each overrun is a single-cycle pulse
	always @(posedge clk) begin
		if (rx_overrun)
			overrun_cnt <= overrun_cnt + 1;
		if (sresetn)
			assert (!(rx_overrun && overrun_prev))
				else fail_run("rx_overrun stayed high for more than one cycle");
		overrun_prev <= rx_overrun;
	end

	initial begin
		#(WATCHDOG);
		fail_run("watchdog expired before the tests finished");
	end

	initial begin
		uart_byte_t b;
		logic       bad;
		int         base;
		int         i;

		// 1. Reset values
		repeat (5) @(posedge clk);
		sresetn <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		assert (serial_out == 1'b1) else report_mismatch("serial_out", 1, 32'(serial_out));
		assert (rx_empty == 1'b1) else report_mismatch("rx_empty", 1, 32'(rx_empty));
		assert (tx_full == 1'b0) else report_mismatch("tx_full", 0, 32'(tx_full));
		assert (rx_overrun == 1'b0) else report_mismatch("rx_overrun", 0, 32'(rx_overrun));

		// 2. Good frames with 1 or 2 stop bits and random gaps
		test_name = "reception";
		auto_pop <= 1'b1;
		for (i = 0; i < 20; i++) begin
			b = 8'(rand_bits(8));
			expect_word(1'b0, b);
			send_frame(b, 1'b1, 1 + int'(rand_bits(1)));
			repeat (rand_bits(3)) @(posedge clk);
		end
		wait_drained();

		// 3. Low stop bits mixed with good frames
		test_name = "framing";
		for (i = 0; i < 12; i++) begin
			b   = 8'(rand_bits(8));
			bad = (i % 3 == 1) || (rand_bits(2) == 0);
			expect_word(bad, b);
			send_frame(b, !bad, 1);
			repeat (rand_bits(3)) @(posedge clk);
		end
		wait_drained();

		// 4. Host pushes while the line is captured
		test_name = "transmission";
		fork
			push_bytes(20, 1'b0);
			check_tx_frames(20);
		join

		// 5. No pops so the FIFO holds 8 and drops 2
		test_name = "overrun";
		auto_pop <= 1'b0;
		base = overrun_cnt;
		for (i = 0; i < 10; i++) begin
			b = 8'(rand_bits(8));
			if (i < `UART_RX_FIFO_DEPTH)
				expect_word(1'b0, b);
			send_frame(b, 1'b1, 1);
			repeat (rand_bits(3)) @(posedge clk);
		end
		for (i = 0; i < BIT_CLKS && overrun_cnt - base < 2; i++)
			@(posedge clk); // Last pulse lands near the stop midpoint
		auto_pop <= 1'b1;
		wait_drained();
		assert (overrun_cnt - base == 2) else report_mismatch("overrun pulses", 2,
			32'(overrun_cnt - base));

		// 6. Transmitter drives the receiver
		test_name = "loopback";
		loopback <= 1'b1;
		@(posedge clk);
		push_bytes(12, 1'b1);
		wait_drained();

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+common
+incdir+verification
common/uart_pkg.sv
verilog/cdc_sync.sv
verilog/byte_fifo.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/uart_core.sv
verification/uart_core_tb.sv

//--- verilog/byte_fifo.sv
// --------------------
// First-word-fall-through; push when full and pop when empty are dropped
// --------------------

module byte_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             sresetn,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] head,
	output logic             empty,
	output logic             full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // Words held
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign empty   = (count == '0);
	assign full    = (count == FULL_CNT);
	assign head    = mem[rd_ptr]; // Valid while not empty

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

//--- verilog/cdc_sync.sv
// --------------------
// Single-bit levels only; output lags input by 2 clocks
// --------------------

module cdc_sync (
	input  logic clk,
	input  logic sresetn,
	input  logic in_async,
	output logic out_sync
);

	logic meta; // First stage, may go metastable

	always_ff @(posedge clk) begin
		if (!sresetn) begin
			meta     <= 1'b1; // Idle-high serial line
			out_sync <= 1'b1;
		end else begin
			meta     <= in_async;
			out_sync <= meta;
		end
	end

endmodule

//--- verilog/uart_core.sv
// --------------------
// Strobe interface, host watches rx_empty and tx_full
// A word arriving with the receive FIFO full is lost and flagged on rx_overrun
// --------------------

`include "uart_defs.svh"

module uart_core (
	input  logic                 clk,
	input  logic                 sresetn,
	input  logic                 serial_in,
	output logic                 serial_out,
	input  logic                 tx_push,
	input  uart_pkg::uart_byte_t tx_byte,
	output logic                 tx_full,
	input  logic                 rx_pop,
	output uart_pkg::rx_word_t   rx_word,
	output logic                 rx_empty,
	output logic                 rx_overrun
);

	import uart_pkg::*;

	logic       rx_valid;
	rx_word_t   rx_data;  // Receiver output, good only with rx_valid
	logic       rx_full;
	uart_byte_t tx_head;  // Next byte to send
	logic       tx_empty;
	logic       tx_busy;
	logic       tx_start;

	uart_rx rx_i (
		.clk       (clk),
		.sresetn   (sresetn),
		.serial_in (serial_in),
		.rx_valid  (rx_valid),
		.rx_data   (rx_data)
	);

	// Dropped by the FIFO itself when full
	byte_fifo #(
		.DEPTH (`UART_RX_FIFO_DEPTH),
		.WIDTH ($bits(rx_word_t))
	) rx_fifo_i (
		.clk       (clk),
		.sresetn   (sresetn),
		.push      (rx_valid),
		.push_data (rx_data),
		.pop       (rx_pop),
		.head      (rx_word),
		.empty     (rx_empty),
		.full      (rx_full)
	);

	always_ff @(posedge clk) begin
		if (!sresetn)
			rx_overrun <= 1'b0;
		else
			rx_overrun <= rx_valid && rx_full; // Lines up with the push it replaces
	end

	byte_fifo #(
		.DEPTH (`UART_TX_FIFO_DEPTH),
		.WIDTH ($bits(uart_byte_t))
	) tx_fifo_i (
		.clk       (clk),
		.sresetn   (sresetn),
		.push      (tx_push),
		.push_data (tx_byte),
		.pop       (tx_start), // Head leaves as the transmitter takes it
		.head      (tx_head),
		.empty     (tx_empty),
		.full      (tx_full)
	);

	// Feed the transmitter whenever it is free
	assign tx_start = !tx_empty && !tx_busy;

	uart_tx tx_i (
		.clk        (clk),
		.sresetn    (sresetn),
		.start      (tx_start),
		.tx_byte    (tx_head),
		.serial_out (serial_out),
		.busy       (tx_busy)
	);

endmodule
